// File: Makefile
SOURCES := $(wildcard rtl/*.sv rtl/*.svh dv/*.sv dv/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vtb_caddr_xbus: caddr_xbus.f $(SOURCES)
	verilator --binary --timing --top-module tb_caddr_xbus -f caddr_xbus.f

run: obj_dir/Vtb_caddr_xbus
	./obj_dir/Vtb_caddr_xbus | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

// File: caddr_xbus.f
+incdir+rtl
+incdir+dv
rtl/caddr_xbus_pkg.sv
rtl/xbus_ram.sv
rtl/disk_regs.sv
rtl/disk_dma.sv
rtl/busint.sv
rtl/caddr_xbus.sv
dv/tb_caddr_xbus.sv

// File: dv/xbus_tests.svh
// Directed tests of the bus interface, included inside the testbench top module

// Last write wins, and addresses equal in the low index bits share one word
task automatic dram_access();
   $display("DRAM access");
   for (int i = 0; i < 3; i++)
   begin
      ram_store(22'o100 + xbus_addr_t'(i), $urandom);
   end
   ram_store(22'o101, $urandom);   // Overwrites the earlier word
   ram_store(22'o200, $urandom);
   ram_store(22'o2200, $urandom);  // Aliases onto 22'o200
   for (int i = 0; i < 3; i++)
   begin
      ram_expect(22'o100 + xbus_addr_t'(i));
   end
   ram_expect(22'o200);
   ram_expect(22'o2200);
endtask

// Nothing decodes above the disk registers, so the timeout has to answer
task automatic bus_timeout();
   xbus_word_t d;
   $display("Bus timeout");
   bus_read(22'o17400000, d);
   check_word("busout on unmapped read", d, '0);
   bus_write(22'o17400000, $urandom);
   bus_read(22'o17400001, d);
   check_word("busout on unmapped read", d, '0);
   ram_expect(22'o100);  // A mapped read right after still gets DRAM data
endtask

task automatic fill_buffer();
   for (int i = 0; i < `XBUS_DISK_BUF_WORDS; i++)
   begin
      buf_words[i] = $urandom;
      bus_write(`XBUS_DISK_BUF_BASE + xbus_addr_t'(i), buf_words[i]);
   end
endtask

task automatic regs_and_buffer();
   xbus_word_t d;
   $display("Registers and sector buffer");
   bus_read(`XBUS_DISK_REG_BASE, d);
   check_bit("status busy", d[31], 1'b0);
   check_bit("status done", d[30], 1'b0);
   bus_write(`XBUS_DISK_REG_BASE + 22'd1, 32'hfff1_2345);
   bus_write(`XBUS_DISK_REG_BASE + 22'd2, 32'd9);
   bus_read(`XBUS_DISK_REG_BASE + 22'd1, d);
   check_word("address register", d, 32'h0031_2345);  // Only 22 address bits are kept
   bus_read(`XBUS_DISK_REG_BASE + 22'd2, d);
   check_word("count register", d, 32'd9);
   fill_buffer();
   for (int i = 0; i < `XBUS_DISK_BUF_WORDS; i++)
   begin
      bus_read(`XBUS_DISK_BUF_BASE + xbus_addr_t'(i), d);
      check_word($sformatf("buffer word %0d", i), d, buf_words[i]);
   end
endtask

task automatic buffer_to_memory();
   xbus_word_t d;
   xbus_addr_t a;
   int         n;
   $display("DMA buffer to memory");
   fill_buffer();
   bus_write(`XBUS_DISK_REG_BASE + 22'd1, 32'o1000);
   bus_write(`XBUS_DISK_REG_BASE + 22'd2, 32'd16);
   bus_write(`XBUS_DISK_REG_BASE, 32'h0000_0003);  // Start with direction set
   n = 0;
   do
   begin
      bus_read(`XBUS_DISK_REG_BASE, d);
      n++;
   end
   while (!d[30] && n < poll_limit);
   if (!d[30])
   begin
      errors++;
      $display("The DMA transfer into DRAM never reported done");
   end
   check_bit("status busy", d[31], 1'b0);
   for (int i = 0; i < `XBUS_DISK_BUF_WORDS; i++)
   begin
      a = 22'o1000 + xbus_addr_t'(i);
      dram_model[a[`XBUS_DRAM_ABITS-1:0]] = buf_words[i];
      ram_expect(a);
   end
endtask

task automatic memory_to_buffer_irq();
   xbus_word_t d;
   xbus_word_t src [`XBUS_DISK_BUF_WORDS];
   int         n;
   $display("DMA memory to buffer with interrupt");
   for (int i = 0; i < `XBUS_DISK_BUF_WORDS; i++)
   begin
      src[i] = $urandom;
      ram_store(22'o1400 + xbus_addr_t'(i), src[i]);
      bus_write(`XBUS_DISK_BUF_BASE + xbus_addr_t'(i), '0);
   end
   bus_write(`XBUS_DISK_REG_BASE + 22'd1, 32'o1400);
   bus_write(`XBUS_DISK_REG_BASE + 22'd2, 32'd16);
   bus_write(`XBUS_DISK_REG_BASE, 32'h0000_0005);  // Start with interrupt enable
   n = 0;
   while (!interrupt && n < poll_limit)
   begin
      ram_expect(22'o1000 + xbus_addr_t'(n % 16));  // CPU competes with the DMA engine
      n++;
   end
   if (!interrupt)
   begin
      errors++;
      $display("No interrupt after the DMA transfer into the buffer");
   end
   for (int i = 0; i < `XBUS_DISK_BUF_WORDS; i++)
   begin
      bus_read(`XBUS_DISK_BUF_BASE + xbus_addr_t'(i), d);
      check_word($sformatf("buffer word %0d", i), d, src[i]);
   end
   // A command write clears done and with it the interrupt
   bus_write(`XBUS_DISK_REG_BASE, 32'h0000_0004);
   @(negedge mclk);
   check_bit("interrupt", interrupt, 1'b0);
endtask

// File: dv/tb_caddr_xbus.sv
// Testbench top for the bus interface, run with the directed tests in xbus_tests.svh
`include "caddr_xbus_params.svh"

module tb_caddr_xbus;
   import caddr_xbus_pkg::*;

   localparam int wait_limit = 200;  // Longest handshake wait in cycles
   localparam int poll_limit = 100;

   logic       mclk = 1'b0;
   logic       reset;
   xbus_addr_t addr;
   xbus_word_t busin;
   logic       write;
   logic       req;
   logic       ack;
   xbus_word_t busout;
   logic       load;
   logic       interrupt;

   int         errors = 0;
   int         checks = 0;
   xbus_word_t dram_model [2**`XBUS_DRAM_ABITS];  // Expected DRAM contents by low address bits
   xbus_word_t buf_words [`XBUS_DISK_BUF_WORDS];   // Last words written to the sector buffer

   caddr_xbus i_caddr_xbus (
      .mclk, .reset, .addr, .busin, .write, .req, .ack, .busout, .load, .interrupt
   );

   always #50 mclk = ~mclk;

   task automatic check_word(input string name, input xbus_word_t got, input xbus_word_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic report_stall(input string what, input xbus_addr_t a);
      errors++;
      $display("Bus stalled at %0t: %s, address %o", $time, what, a);
   endtask

   // Last phase of the handshake where ack has to follow req down
   task automatic await_ack_release(input xbus_addr_t a);
      int n;
      n = 0;
      do
      begin
         @(negedge mclk);
         n++;
      end
      while (ack && n < wait_limit);
      if (ack)
      begin
         report_stall("ack stayed high after req fell", a);
      end
   endtask

   task automatic bus_write(input xbus_addr_t a, input xbus_word_t d);
      int n;
      @(posedge mclk);
      addr  <= a;
      busin <= d;
      write <= 1'b1;
      req   <= 1'b1;
      n = 0;
      do
      begin
         @(negedge mclk);
         n++;
      end
      while (!ack && n < wait_limit);
      if (!ack)
      begin
         report_stall("no ack for a write", a);
      end
      check_word("busout during a write", busout, '1);  // Bus idles at all ones without a read
      @(posedge mclk);
      req <= 1'b0;
      await_ack_release(a);
   endtask

   task automatic bus_read(input xbus_addr_t a, output xbus_word_t d);
      int n;
      @(posedge mclk);
      addr  <= a;
      write <= 1'b0;
      req   <= 1'b1;
      n = 0;
      do
      begin
         @(negedge mclk);
         n++;
      end
      while (!load && n < wait_limit);  // load only comes with ack in bus_wait
      if (!load)
      begin
         report_stall("no read data for a read", a);
      end
      check_bit("ack", ack, 1'b1);
      d = busout;
      @(posedge mclk);
      req <= 1'b0;
      await_ack_release(a);
   endtask

   task automatic ram_store(input xbus_addr_t a, input xbus_word_t d);
      bus_write(a, d);
      dram_model[a[`XBUS_DRAM_ABITS-1:0]] = d;
   endtask

   task automatic ram_expect(input xbus_addr_t a);
      xbus_word_t got;
      bus_read(a, got);
      check_word($sformatf("busout at %o", a), got, dram_model[a[`XBUS_DRAM_ABITS-1:0]]);
   endtask

`include "xbus_tests.svh"

   initial
   begin
      void'($urandom(32'h55c7_b25d));
      reset = 1'b1;
      addr  = '0;
      busin = '0;
      write = 1'b0;
      req   = 1'b0;
      repeat (5) @(posedge mclk);
      reset <= 1'b0;
      dram_access();
      bus_timeout();
      regs_and_buffer();
      buffer_to_memory();
      memory_to_buffer_irq();
      repeat (2) @(posedge mclk);
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("** PASS **");
      end
      else
      begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: rtl/busint.sv
// Bus interface with arbiter, decode merge, read-data select, DRAM steering and bus timeout
`include "caddr_xbus_params.svh"

module busint (
   input  logic                       mclk,
   input  logic                       reset,
   input  caddr_xbus_pkg::xbus_addr_t addr,
   input  caddr_xbus_pkg::xbus_word_t busin,
   input  logic                       write,
   input  logic                       req,
   output logic                       ack,
   output caddr_xbus_pkg::xbus_word_t busout,
   output logic                       load,
   output caddr_xbus_pkg::xbus_addr_t ram_addr,
   output caddr_xbus_pkg::xbus_word_t ram_wdata,
   output logic                       ram_write,
   output logic                       ram_req,
   input  caddr_xbus_pkg::xbus_word_t ram_rdata,
   input  logic                       ram_ack,
   input  logic                       ram_decode,
   input  caddr_xbus_pkg::xbus_word_t regs_rdata,
   input  logic                       regs_ack,
   input  logic                       regs_decode,
   input  caddr_xbus_pkg::xbus_word_t buf_rdata,
   input  logic                       buf_ack,
   input  logic                       buf_decode,
   input  logic                       dma_req,
   input  logic                       dma_write,
   input  caddr_xbus_pkg::xbus_addr_t dma_addr,
   input  caddr_xbus_pkg::xbus_word_t dma_wdata,
   output logic                       dma_grant
);
   import caddr_xbus_pkg::*;

   bus_state_t state;
   bus_state_t next_state;
   logic [4:0] timeout_count;
   logic       timed_out;
   logic       to_hold;
   logic       device_ack;
   logic       slave_done;
   logic       grant_hold;
   logic       cpu_read;

   assign timed_out  = timeout_count == `XBUS_TIMEOUT;
   assign device_ack = ram_ack || regs_ack || buf_ack || timed_out;
   assign slave_done = (state == bus_slave) && ram_ack;

   // CPU has priority when both ask in the same idle cycle
   always_comb
   begin
      next_state = state;
      case (state)
         bus_idle:
         begin
            if (req)
            begin
               next_state = bus_req;
            end
            else if (dma_req)
            begin
               next_state = bus_slave;
            end
         end
         bus_req:   if (device_ack) next_state = bus_wait;
         bus_wait:  if (!req) next_state = bus_idle;
         bus_slave: if (ram_ack) next_state = bus_idle;
         default:   next_state = bus_idle;
      endcase
   end

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         state <= bus_idle;
      end
      else
      begin
         state <= next_state;
      end
   end

   // Timeout counter runs only while a CPU request is outstanding
   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         timeout_count <= '0;
         to_hold       <= 1'b0;
      end
      else
      begin
         if ((state == bus_req) && !timed_out)
         begin
            timeout_count <= timeout_count + 5'd1;
         end
         else if (state == bus_wait)
         begin
            timeout_count <= '0;
         end
         // Remembers the timeout through bus_wait after the counter has cleared
         if ((state == bus_req) && timed_out)
         begin
            to_hold <= 1'b1;
         end
         else if (state == bus_idle)
         begin
            to_hold <= 1'b0;
         end
      end
   end

   assign ack  = ((state == bus_req) && device_ack) || (state == bus_wait);
   assign load = req && !write && (state == bus_wait);

   // During bus_slave the DRAM decode belongs to the DMA address
   assign cpu_read = req && !write && (state != bus_slave);

   always_comb
   begin
      if (cpu_read && ram_decode)
      begin
         busout = ram_rdata;
      end
      else if (cpu_read && regs_decode)
      begin
         busout = regs_rdata;
      end
      else if (cpu_read && buf_decode)
      begin
         busout = buf_rdata;
      end
      else if (cpu_read && (timed_out || to_hold))
      begin
         busout = '0;  // Nothing answered this read
      end
      else
      begin
         busout = '1;
      end
   end

   // DRAM follows the DMA engine only while it owns the bus
   always_comb
   begin
      if (state == bus_slave)
      begin
         ram_addr  = dma_addr;
         ram_wdata = dma_wdata;
         ram_write = dma_write;
         ram_req   = dma_req;
      end
      else
      begin
         ram_addr  = addr;
         ram_wdata = busin;
         ram_write = write;
         ram_req   = req;
      end
   end

   // Grant rises with the DRAM acknowledge and stays until dma_req is seen low
   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         grant_hold <= 1'b0;
      end
      else if (slave_done)
      begin
         grant_hold <= 1'b1;
      end
      else if (!dma_req)
      begin
         grant_hold <= 1'b0;
      end
   end

   assign dma_grant = slave_done || grant_hold;

endmodule

// File: rtl/caddr_xbus.sv
// Top level of the bus interface, joining the arbiter, the DRAM and the disk controller blocks
module caddr_xbus (
   input  logic                       mclk,
   input  logic                       reset,
   input  caddr_xbus_pkg::xbus_addr_t addr,
   input  caddr_xbus_pkg::xbus_word_t busin,
   input  logic                       write,
   input  logic                       req,
   output logic                       ack,
   output caddr_xbus_pkg::xbus_word_t busout,
   output logic                       load,
   output logic                       interrupt
);
   import caddr_xbus_pkg::*;

   // DRAM path after the steering in busint
   xbus_addr_t  ram_addr;
   xbus_word_t  ram_wdata;
   logic        ram_write;
   logic        ram_req;
   xbus_word_t  ram_rdata;
   logic        ram_ack;
   logic        ram_decode;

   xbus_word_t  regs_rdata;
   logic        regs_ack;
   logic        regs_decode;
   xbus_word_t  buf_rdata;
   logic        buf_ack;
   logic        buf_decode;

   // DMA master bus from the disk controller
   logic        dma_req;
   logic        dma_write;
   xbus_addr_t  dma_addr;
   xbus_word_t  dma_wdata;
   logic        dma_grant;

   // Register block steering the DMA engine
   logic        start;
   logic        to_memory;
   xbus_addr_t  mem_addr;
   disk_count_t count;
   logic        busy;
   logic        done_pulse;

   busint i_busint (
      .mclk, .reset, .addr, .busin, .write, .req, .ack, .busout, .load,
      .ram_addr, .ram_wdata, .ram_write, .ram_req, .ram_rdata, .ram_ack, .ram_decode,
      .regs_rdata, .regs_ack, .regs_decode, .buf_rdata, .buf_ack, .buf_decode,
      .dma_req, .dma_write, .dma_addr, .dma_wdata, .dma_grant
   );

   xbus_ram i_xbus_ram (
      .mclk, .reset, .addr(ram_addr), .wdata(ram_wdata), .write(ram_write),
      .req(ram_req), .rdata(ram_rdata), .ack(ram_ack), .decode(ram_decode)
   );

   disk_regs i_disk_regs (
      .mclk, .reset, .addr, .busin, .write, .req,
      .rdata(regs_rdata), .ack(regs_ack), .decode(regs_decode),
      .start, .to_memory, .mem_addr, .count, .busy, .done_pulse, .interrupt
   );

   disk_dma i_disk_dma (
      .mclk, .reset, .addr, .busin, .write, .req, .buf_rdata, .buf_ack, .buf_decode,
      .start, .to_memory, .mem_addr, .count, .busy, .done_pulse,
      .dma_req, .dma_write, .dma_addr, .dma_wdata, .dma_rdata(ram_rdata), .dma_grant
   );

endmodule

// File: rtl/caddr_xbus_params.svh
// Address map, DRAM size and bus timeout of the bus interface, included by the RTL blocks
`ifndef CADDR_XBUS_PARAMS_SVH
`define CADDR_XBUS_PARAMS_SVH

// Highest word address answered by the DRAM
`define XBUS_DRAM_TOP 22'o16777777

// DRAM index bits actually built, upper address bits alias onto them
`define XBUS_DRAM_ABITS 10

// Sector buffer window seen by the CPU
`define XBUS_DISK_BUF_BASE 22'o17377700
`define XBUS_DISK_BUF_WORDS 16

// Disk registers at base, base + 1 and base + 2
`define XBUS_DISK_REG_BASE 22'o17377770

// Cycles spent in bus_req before the timeout answers
`define XBUS_TIMEOUT 5'd31

`endif

// File: rtl/caddr_xbus_pkg.sv
// Bus word, address, count and arbiter state types shared by every block of the bus interface
package caddr_xbus_pkg;

   // Word address on the 22-bit peripheral bus
   typedef logic [21:0] xbus_addr_t;

   // Data word carried on busin, busout and the DMA path
   typedef logic [31:0] xbus_word_t;

   // DMA word count and sector buffer index
   typedef logic [4:0] disk_count_t;

   // Arbiter states of the bus interface
   typedef enum logic [1:0]
   {
      bus_idle,   // Nobody owns the bus
      bus_req,    // CPU request waits for an acknowledge or the timeout
      bus_wait,   // Acknowledge given, waiting for the CPU to drop req
      bus_slave   // Disk controller drives the DRAM
   } bus_state_t;

endpackage

// File: rtl/disk_dma.sv
// Sector buffer and DMA engine of the disk controller, moving words between buffer and DRAM
`include "caddr_xbus_params.svh"

module disk_dma (
   input  logic                        mclk,
   input  logic                        reset,
   input  caddr_xbus_pkg::xbus_addr_t  addr,
   input  caddr_xbus_pkg::xbus_word_t  busin,
   input  logic                        write,
   input  logic                        req,
   output caddr_xbus_pkg::xbus_word_t  buf_rdata,
   output logic                        buf_ack,
   output logic                        buf_decode,
   input  logic                        start,
   input  logic                        to_memory,
   input  caddr_xbus_pkg::xbus_addr_t  mem_addr,
   input  caddr_xbus_pkg::disk_count_t count,
   output logic                        busy,
   output logic                        done_pulse,
   output logic                        dma_req,
   output logic                        dma_write,
   output caddr_xbus_pkg::xbus_addr_t  dma_addr,
   output caddr_xbus_pkg::xbus_word_t  dma_wdata,
   input  caddr_xbus_pkg::xbus_word_t  dma_rdata,
   input  logic                        dma_grant
);
   import caddr_xbus_pkg::*;

   xbus_word_t  buffer [`XBUS_DISK_BUF_WORDS];
   xbus_addr_t  base_q;
   disk_count_t len_q;
   disk_count_t idx;
   logic        dir_q;
   logic        word_done;
   logic        last_word;
   logic        dma_store;

   assign buf_decode = (addr >= `XBUS_DISK_BUF_BASE) &&
                       (addr < `XBUS_DISK_BUF_BASE + 22'(`XBUS_DISK_BUF_WORDS));

   // Grant seen while our request is still up ends the current word
   assign word_done = dma_req && dma_grant;
   assign dma_store = word_done && !dir_q;
   // A count of zero runs to the end of the buffer
   assign last_word = (idx == len_q - 5'd1) || (idx == 5'(`XBUS_DISK_BUF_WORDS - 1));

   assign dma_write = dir_q;
   assign dma_addr  = base_q + xbus_addr_t'(idx);

   // One write port; a CPU write that collides with a DMA store lands next cycle as req is held
   always_ff @(posedge mclk)
   begin
      if (dma_store)
      begin
         buffer[idx[3:0]] <= dma_rdata;
      end
      else if (req && buf_decode && write)
      begin
         buffer[addr[3:0]] <= busin;
      end
      buf_rdata <= buffer[addr[3:0]];
   end

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         buf_ack <= 1'b0;
      end
      else
      begin
         buf_ack <= req && buf_decode;
      end
   end

   // Outgoing word is captured as the request goes up and held for the transfer
   always_ff @(posedge mclk)
   begin
      if (busy && !dma_req && !dma_grant)
      begin
         dma_wdata <= buffer[idx[3:0]];
      end
   end

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         busy       <= 1'b0;
         done_pulse <= 1'b0;
         dma_req    <= 1'b0;
         dir_q      <= 1'b0;
         base_q     <= '0;
         len_q      <= '0;
         idx        <= '0;
      end
      else
      begin
         done_pulse <= 1'b0;
         if (start && !busy)
         begin
            busy   <= 1'b1;
            dir_q  <= to_memory;
            base_q <= mem_addr;
            len_q  <= count;
            idx    <= '0;
         end
         else if (word_done)
         begin
            dma_req <= 1'b0;
            if (last_word)
            begin
               busy       <= 1'b0;
               done_pulse <= 1'b1;
            end
            else
            begin
               idx <= idx + 5'd1;
            end
         end
         else if (busy && !dma_req && !dma_grant)
         begin
            dma_req <= 1'b1;  // Next word only after the grant of the last one fell
         end
      end
   end

endmodule

// File: rtl/disk_regs.sv
// Disk controller command, address and count registers with the CPU access path and interrupt
`include "caddr_xbus_params.svh"

module disk_regs (
   input  logic                        mclk,
   input  logic                        reset,
   input  caddr_xbus_pkg::xbus_addr_t  addr,
   input  caddr_xbus_pkg::xbus_word_t  busin,
   input  logic                        write,
   input  logic                        req,
   output caddr_xbus_pkg::xbus_word_t  rdata,
   output logic                        ack,
   output logic                        decode,
   output logic                        start,
   output logic                        to_memory,
   output caddr_xbus_pkg::xbus_addr_t  mem_addr,
   output caddr_xbus_pkg::disk_count_t count,
   input  logic                        busy,
   input  logic                        done_pulse,
   output logic                        interrupt
);

   logic [1:0] offset;
   logic       wr_stb;
   logic       int_enable;
   logic       done;

   assign decode = (addr >= `XBUS_DISK_REG_BASE) && (addr <= `XBUS_DISK_REG_BASE + 22'd2);
   assign offset = addr[1:0];  // Base is aligned to eight words

   // Only the first cycle of a write counts, so start stays a single pulse
   assign wr_stb = req && decode && write && !ack;

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         ack        <= 1'b0;
         start      <= 1'b0;
         to_memory  <= 1'b0;
         int_enable <= 1'b0;
         done       <= 1'b0;
         mem_addr   <= '0;
         count      <= '0;
      end
      else
      begin
         ack   <= req && decode;
         start <= 1'b0;
         if (wr_stb && (offset == 2'd0))
         begin
            start      <= busin[0] && !busy;  // A start during a run is dropped
            to_memory  <= busin[1];
            int_enable <= busin[2];
            done       <= 1'b0;
         end
         if (wr_stb && (offset == 2'd1))
         begin
            mem_addr <= busin[21:0];
         end
         if (wr_stb && (offset == 2'd2))
         begin
            count <= busin[4:0];
         end
         if (done_pulse)
         begin
            done <= 1'b1;  // End of a transfer wins over a command write
         end
      end
   end

   // Status is read live, so busy follows the engine
   always_comb
   begin
      case (offset)
         2'd0:    rdata = {busy, done, 27'd0, int_enable, to_memory, 1'b0};
         2'd1:    rdata = {10'd0, mem_addr};
         2'd2:    rdata = {27'd0, count};
         default: rdata = '0;
      endcase
   end

   assign interrupt = done && int_enable;

endmodule

// File: rtl/xbus_ram.sv
// Word-wide DRAM model for the bus, instantiated once behind the DRAM path of the bus interface
`include "caddr_xbus_params.svh"

module xbus_ram (
   input  logic                       mclk,
   input  logic                       reset,
   input  caddr_xbus_pkg::xbus_addr_t addr,
   input  caddr_xbus_pkg::xbus_word_t wdata,
   input  logic                       write,
   input  logic                       req,
   output caddr_xbus_pkg::xbus_word_t rdata,
   output logic                       ack,
   output logic                       decode
);
   import caddr_xbus_pkg::*;

   xbus_word_t                  mem [2**`XBUS_DRAM_ABITS];
   logic [`XBUS_DRAM_ABITS-1:0] index;

   // Everything from address zero up to the top of DRAM belongs to this block
   assign decode = addr <= `XBUS_DRAM_TOP;
   assign index  = addr[`XBUS_DRAM_ABITS-1:0];  // Upper bits are ignored and alias

   // The write repeats while req is held, which is harmless for the same word
   always_ff @(posedge mclk)
   begin
      if (req && decode && write)
      begin
         mem[index] <= wdata;
      end
      rdata <= mem[index];  // Old contents on a write cycle, nobody loads them then
   end

   // Answer one cycle after the request is seen and hold until req falls
   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         ack <= 1'b0;
      end
      else
      begin
         ack <= req && decode;
      end
   end

endmodule
